// File: bench/pathCipherTb.sv
// Testbench for the bucket cipher top level
// File-driven chunks, output monitor with compare tasks, watchdog

`timescale 1ns/10ps

module pathCipherTb
    import cipherPkg::*;
();

    localparam int ClockPeriod = 20;
    localparam int ResetCycles = 8;
    localparam int DriveDelay = 2;
    localparam int PathCount = 4;
    localparam int ChunkTotal = PathCount * PathChunks;
    // Gaps go in before every fourth chunk, so bursts of four stay back to back
    localparam int MaxGap = 3;
    localparam int GapSlots = ChunkTotal / 4 - 1;
    localparam int DrainCycles = PipeLatency + 4;
    localparam int WatchdogCycles =
        ResetCycles + ChunkTotal + GapSlots * MaxGap + PipeLatency + 20;

    logic                  Clock;
    logic                  rstN;
    logic [ChunkWidth-1:0] dramReadData;
    logic                  dramReadStrobe;
    logic [ChunkWidth-1:0] backendWriteData;
    logic                  backendWriteStrobe;
    logic [ChunkWidth-1:0] dramWriteData;
    logic                  dramWriteStrobe;
    logic [ChunkWidth-1:0] backendReadData;
    logic                  backendReadStrobe;

    // Two words per chunk, input then lane counters
    logic [ChunkWidth-1:0] stimMem [2*ChunkTotal];
    int unsigned           acceptCycle [ChunkTotal];
    int                    pendingIdx [$];
    int unsigned           cycleCount = 0;
    int                    received = 0;
    int                    seed = 32'h90a2_3ccf;

    pathCipher UUT (
        .Clock              (Clock),
        .rstN               (rstN),
        .dramReadData       (dramReadData),
        .dramReadStrobe     (dramReadStrobe),
        .backendWriteData   (backendWriteData),
        .backendWriteStrobe (backendWriteStrobe),
        .dramWriteData      (dramWriteData),
        .dramWriteStrobe    (dramWriteStrobe),
        .backendReadData    (backendReadData),
        .backendReadStrobe  (backendReadStrobe)
    );

    initial begin
        Clock = 1'b0;
        forever begin
            #(ClockPeriod / 2) Clock = ~Clock;
        end
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
    end

    // --------------------
    // Reference model
    function automatic bit isPathRead(input int k);
        return ((k / PathChunks) % 2) == 0;
    endfunction

    function automatic logic [LaneWidth-1:0] rotateLeft(input logic [LaneWidth-1:0] value);
        return {value[LaneWidth-MixRotate-1:0], value[LaneWidth-1:LaneWidth-MixRotate]};
    endfunction

    function automatic logic [LaneWidth-1:0] keystreamOf(input logic [LaneWidth-1:0] counter);
        logic [LaneWidth-1:0] word;
        word = counter;
        for (int r = 0; r < MixRounds; r++) begin
            word = rotateLeft((word ^ CipherKey) + RoundConst[r]);
        end
        return word;
    endfunction

    function automatic chunkT expectedOutput(input int k);
        chunkT inChunk;
        chunkT counters;
        chunkT result;
        inChunk = stimMem[2*k];
        counters = stimMem[2*k+1];
        result = inChunk;
        // Headers pass through untouched
        if (k % BucketChunks != 0) begin
            for (int i = 0; i < LaneCount; i++) begin
                result.lanes[i] = inChunk.lanes[i] ^ keystreamOf(counters.lanes[i]);
            end
        end
        return result;
    endfunction

    // --------------------
    // Compare tasks
    task automatic stopRun();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkChunk(input string testName, input chunkT expected, input chunkT actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", testName, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkRoute(input string testName, input bit expected, input bit actual);
        if (actual !== expected) begin
            $display("%s came out on the %s side instead of the %s side", testName,
                actual ? "backend read" : "DRAM write", expected ? "backend read" : "DRAM write");
            stopRun();
        end
    endtask

    task automatic checkLatency(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR %s expected %0d actual %0d", testName, expected, actual);
            stopRun();
        end
    endtask

    // --------------------
    // Output monitor
    task automatic observeOutputs();
        int    k;
        bit    toBackend;
        chunkT actual;
        string testName;
        if (backendReadStrobe && dramWriteStrobe) begin
            $display("Both output strobes pulsed in the same cycle");
            stopRun();
        end else if ((backendReadStrobe || dramWriteStrobe) && pendingIdx.size() == 0) begin
            $display("An output strobe appeared with no chunk in flight");
            stopRun();
        end else if (backendReadStrobe || dramWriteStrobe) begin
            k = pendingIdx.pop_front();
            toBackend = backendReadStrobe;
            actual = toBackend ? backendReadData : dramWriteData;
            testName = $sformatf("path %0d chunk %0d", k / PathChunks, k % PathChunks);
            checkLatency(testName, acceptCycle[k] + PipeLatency, cycleCount);
            checkRoute(testName, isPathRead(k), toBackend);
            checkChunk(testName, expectedOutput(k), actual);
            received = received + 1;
        end else if (pendingIdx.size() != 0
                && cycleCount >= acceptCycle[pendingIdx[0]] + PipeLatency) begin
            $display("Chunk %0d never came out of the pipeline", pendingIdx[0]);
            stopRun();
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge Clock) begin
        if (rstN) begin
            observeOutputs();
        end
    end

    // --------------------
    // Stimulus
    task automatic driveCycle(
        input bit                    readActive,
        input bit                    chunkValid,
        input logic [ChunkWidth-1:0] chunk,
        input bit                    stray
    );
        @(posedge Clock);
        #DriveDelay;
        // Idle side gets inverted junk, strobed only when a stray pulse is wanted
        if (readActive) begin
            dramReadData = chunk;
            dramReadStrobe = chunkValid;
            backendWriteData = ~chunk;
            backendWriteStrobe = stray;
        end else begin
            backendWriteData = chunk;
            backendWriteStrobe = chunkValid;
            dramReadData = ~chunk;
            dramReadStrobe = stray;
        end
    endtask

    initial begin
        int unsigned gap;
        rstN = 1'b0;
        dramReadData = '0;
        dramReadStrobe = 1'b0;
        backendWriteData = '0;
        backendWriteStrobe = 1'b0;
        $readmemh("bench/pathStimulus.txt", stimMem);

        repeat (ResetCycles) @(posedge Clock);
        #DriveDelay;
        rstN = 1'b1;

        for (int k = 0; k < ChunkTotal; k++) begin
            if (k > 0 && k % 4 == 0) begin
                gap = $unsigned($random(seed)) % (MaxGap + 1);
                repeat (gap) begin
                    driveCycle(isPathRead(k), 1'b0, stimMem[2*k], 1'b1);
                end
            end
            driveCycle(isPathRead(k), 1'b1, stimMem[2*k], k % BucketChunks == 0);
            acceptCycle[k] = cycleCount;
            pendingIdx.push_back(k);
        end
        driveCycle(1'b1, 1'b0, '0, 1'b0);

        wait (received == ChunkTotal);
        repeat (DrainCycles) @(posedge Clock);
        if (received == ChunkTotal && pendingIdx.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Only %0d of %0d chunks came out", received, ChunkTotal);
            stopRun();
        end
    end

    // Watchdog
    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("Timeout after %0d cycles with chunks still outstanding", WatchdogCycles);
        stopRun();
    end

endmodule

// File: bench/pathStimulus.txt
// Each line holds one chunk in path order as input chunk then lane counters
// Lane 1 counter is the high half, and header lines carry zeros instead
5f2c81d04e9ba3673a7c15e29b04d160 00000000000000000000000000000000
e19a4c72b80f3d565c27a9e1047bd3f8 3a7c15e29b04d1633a7c15e29b04d162
07d3b6a91ce24f8592b0e5173ac6d40e 3a7c15e29b04d1653a7c15e29b04d164
a4f80e3b6d9157c2ee10b49c2873af05 3a7c15e29b04d1673a7c15e29b04d166
3b61d8f4a02ec79516fe4a83bd5902c7 3a7c15e29b04d1693a7c15e29b04d168
c80f5e27931ab4d67a4dc3089e61f2b4 3a7c15e29b04d16b3a7c15e29b04d16a
6e92a1c5f73b0d48d5186fb24ca709e3 3a7c15e29b04d16d3a7c15e29b04d16c
9d47b30e8c61f5a2204be97d163ac85f 3a7c15e29b04d16f3a7c15e29b04d16e
b6e03a5d17c94f21c4f10a9372de5b88 00000000000000000000000000000000
41c7e8a2d96b035f8e2a7d41b5c0f963 c4f10a9372de5b8bc4f10a9372de5b8a
f30b5c9e2a7814d6c19e63a0578bd42f c4f10a9372de5b8dc4f10a9372de5b8c
2ad69f107be4c853046f1bd9e2a3759c c4f10a9372de5b8fc4f10a9372de5b8e
8e5107fc34a2d96bb7d3e0452c19fa86 c4f10a9372de5b91c4f10a9372de5b90
5ca9e3b1d04f76287e02c8b59a1d63f4 c4f10a9372de5b93c4f10a9372de5b92
d7f24a8603bc591e2b95e1f07c48ad3a c4f10a9372de5b95c4f10a9372de5b94
1068bd4fe5a7c3929fc107e3b26d584b c4f10a9372de5b97c4f10a9372de5b96
73a5c0e89f1d264b0d96e4b721c83f10 00000000000000000000000000000000
c2e7194bd085a63f51fa0c7e93b428d6 0d96e4b721c83f130d96e4b721c83f12
68b03fd2a51ce9744d8e27b1c6f0935a 0d96e4b721c83f150d96e4b721c83f14
b91d46e07f238ac5e6a4d9102b7fc318 0d96e4b721c83f170d96e4b721c83f16
057fa2c9e84b3d61a3c05f8e14d267b9 0d96e4b721c83f190d96e4b721c83f18
ea3c8d175b60f2946127b4ad0fe98c52 0d96e4b721c83f1b0d96e4b721c83f1a
4f96e0b32dc7815a98db3f6421a5e07c 0d96e4b721c83f1d0d96e4b721c83f1c
9318c5f67e0ad42bc54e9a0bd7362f81 0d96e4b721c83f1f0d96e4b721c83f1e
e8104b7dc29a5f367be25a01c63f94a4 00000000000000000000000000000000
2c5db98e0f47a163f03e6c1294ba5d87 7be25a01c63f94a77be25a01c63f94a6
d6a307f41be95c28874fb2d063c1e95a 7be25a01c63f94a97be25a01c63f94a8
7f12ce6598b03da41dc6e8572fa940b3 7be25a01c63f94ab7be25a01c63f94aa
a0e94b3761fd82c53b72a1f9de045c68 7be25a01c63f94ad7be25a01c63f94ac
3584f1ca26e79b0dca95036b7d18e4f2 7be25a01c63f94af7be25a01c63f94ae
c93b6d5208a4fe17569fd3e18b2c70a4 7be25a01c63f94b17be25a01c63f94b0
5e04a8bf93d1672ee1b85c2706fa3d9b 7be25a01c63f94b37be25a01c63f94b2
0b7fd92e64a1c35891c03e6d58b702f7 00000000000000000000000000000000
84e2a07d5c13bf9627d8f14a0e6593cb 91c03e6d58b702fa91c03e6d58b702f9
f15c3e8a9bd2076445a1ec3f79b8d206 91c03e6d58b702fc91c03e6d58b702fb
6ad9b5c00e748f2397f2360d1ac54eb8 91c03e6d58b702fe91c03e6d58b702fd
1f83d74ba96ce0527c0d9b24e3f1a865 91c03e6d58b7030091c03e6d58b702ff
b4275af0c3e18d69e3a64fb8d0729c14 91c03e6d58b7030291c03e6d58b70301
289ec61d7f053ab4508be7c6941fd23a 91c03e6d58b7030491c03e6d58b70303
dd61f48ae2b79c0586f32d5ba7e0416c 91c03e6d58b7030691c03e6d58b70305
c56a1f0e8d3b47925e08b2c9e4716d3c 00000000000000000000000000000000
7a0c93e61d58fb24b2e74c0f5a963d18 5e08b2c9e4716d3f5e08b2c9e4716d3e
03bf68d2c4a917e5591d0ae3bf7c4260 5e08b2c9e4716d415e08b2c9e4716d40
e94d27a5b0f36c819ac8e51273db0f4a 5e08b2c9e4716d435e08b2c9e4716d42
5286fc3ed71b4a0927bf38d4c5e9016d 5e08b2c9e4716d455e08b2c9e4716d44
bc1fa5796e02d8c3d4603bf7a98e25c1 5e08b2c9e4716d475e08b2c9e4716d46
46e83b0d9fc5a172e20a4c96f15b73de 5e08b2c9e4716d495e08b2c9e4716d48
f7d2496ca83e05b1681fbe245d0ca997 5e08b2c9e4716d4b5e08b2c9e4716d4a
9f3104c7ab25de68e2a57f100b9cc8d1 00000000000000000000000000000000
1b94e7c25da0f3860e7bc91d48f5a62e e2a57f100b9cc8d4e2a57f100b9cc8d3
a86f12d3e4b79c05f3c25a8e0d61b794 e2a57f100b9cc8d6e2a57f100b9cc8d5
37c0ad5eb1284f6964e9d3b2a70f1c8d e2a57f100b9cc8d8e2a57f100b9cc8d7
d25b8f0146e3ca7a185f27ec93b4d0a6 e2a57f100b9cc8dae2a57f100b9cc8d9
6e41c39bf0d7258ab71ce465380a9f2d e2a57f100b9cc8dce2a57f100b9cc8db
c03a7d26819efb54095be1c76d2f48a3 e2a57f100b9cc8dee2a57f100b9cc8dd
5497e0b82c6a13fd8ad46f3b1e97c052 e2a57f100b9cc8e0e2a57f100b9cc8df
4de8b2061fa93c7526bd91f4a30e7745 00000000000000000000000000000000
b5026fe98d3c4a171c6a05fb2e8d93b0 26bd91f4a30e774826bd91f4a30e7747
29e7ca41f608b5d3a39f1e5c874b260d 26bd91f4a30e774a26bd91f4a30e7749
f4185d0b9e62a7c85e07c3a1d9f6482b 26bd91f4a30e774c26bd91f4a30e774b
8a3c96f27d15e0b4c7b248e0350d1f9e 26bd91f4a30e774e26bd91f4a30e774d
1767e4a3c0b95f28e984a07d6b13c5f1 26bd91f4a30e775026bd91f4a30e774f
e0d3b1784af2c6953b1dfc0892e6a74c 26bd91f4a30e775226bd91f4a30e7751
6b8f27dc15a04e39704ea6f1cb5d8a32 26bd91f4a30e775426bd91f4a30e7753

// File: common/chunkBus.sv
// Sequenced chunk with its header and direction tags

`timescale 1ns/10ps

interface chunkBus
    import cipherPkg::*;
();

    logic  strobe;
    chunkT chunk;
    logic  isHeader;
    // High when the chunk belongs to a path read
    logic  toBackend;

    modport sequencer (
        output strobe,
        output chunk,
        output isHeader,
        output toBackend
    );

    modport combiner (
        input strobe,
        input chunk,
        input isHeader,
        input toBackend
    );

endinterface

// File: common/cipherPkg.sv
// Shared constants for the bucket cipher datapath
// Chunk word type with lane and header views, keystream round function

package cipherPkg;

    // --------------------
    // Chunk geometry
    localparam int ChunkWidth = 128;
    localparam int LaneWidth = 64;
    localparam int LaneCount = ChunkWidth / LaneWidth;

    localparam int BucketChunks = 8;
    localparam int BucketIdxWidth = $clog2(BucketChunks);
    localparam int PathBuckets = 2;
    localparam int PathChunks = BucketChunks * PathBuckets;
    localparam int PathIdxWidth = $clog2(PathChunks);

    // --------------------
    // Keystream mixer
    localparam int MixRounds = 4;
    localparam int MixRotate = 13;

    // Sequencer register, mixer stages, combiner output register
    localparam int PipeLatency = MixRounds + 2;

    localparam logic [LaneWidth-1:0] CipherKey = {LaneWidth{1'b1}};

    // Round 0 sits in the lowest slot
    localparam logic [MixRounds-1:0][LaneWidth-1:0] RoundConst = {
        64'h9e37_79b9_7f4a_7c15,
        64'hc2b2_ae3d_27d4_eb4f,
        64'h1656_67b1_9e37_79f9,
        64'h85eb_ca77_c2b2_ae63
    };

    // One chunk word, seen either as keystream lanes or as a bucket header
    typedef union packed {
        logic [LaneCount-1:0][LaneWidth-1:0] lanes;
        struct packed {
            logic [LaneWidth-1:0] reserved;
            logic [LaneWidth-1:0] iv;
        } header;
    } chunkT;

    // Key XOR, round constant add, rotate left
    function automatic logic [LaneWidth-1:0] mixRound(
        input logic [LaneWidth-1:0] word,
        input int unsigned round
    );
        logic [LaneWidth-1:0] mixed;
        mixed = (word ^ CipherKey) + RoundConst[round];
        return (mixed << MixRotate) | (mixed >> (LaneWidth - MixRotate));
    endfunction

endpackage

// File: keystream/keystreamLane.sv
// One keystream lane: MixRounds-stage keyed mixer pipeline
// A valid bit travels alongside each word

`timescale 1ns/10ps

module keystreamLane
    import cipherPkg::*;
(
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic [LaneWidth-1:0] seed,
    input  logic                 seedStrobe,
    output logic [LaneWidth-1:0] keyWord,
    output logic                 keyStrobe
);

    // Slot 0 is the seed, slot s+1 is the output of round s
    logic [LaneWidth-1:0] stageWord [MixRounds+1];
    logic                 stageValid [MixRounds+1];

    assign stageWord[0] = seed;
    assign stageValid[0] = seedStrobe;

    // --------------------
    // Mixer stages
    for (genvar s = 0; s < MixRounds; s++) begin : gStage

        always_ff @(posedge Clock or negedge rstN) begin
            if (!rstN) begin
                stageValid[s+1] <= 1'b0;
            end else begin
                stageValid[s+1] <= stageValid[s];
            end
        end

        // Words only move along with a valid bit
        always_ff @(posedge Clock) begin
            if (stageValid[s]) begin
                stageWord[s+1] <= mixRound(stageWord[s], s);
            end
        end

    end

    // --------------------
    // Lane output
    assign keyWord = stageWord[MixRounds];
    assign keyStrobe = stageValid[MixRounds];

endmodule

// File: logic/chunkCombiner.sv
// Delay line aligning chunks with the keystream
// Lane XOR, header pass-through and output routing by direction

`timescale 1ns/10ps

module chunkCombiner
    import cipherPkg::*;
(
    input  logic                                Clock,
    input  logic                                rstN,
    chunkBus.combiner                           bus,
    input  logic [LaneCount-1:0][LaneWidth-1:0] keyWord,
    input  logic                                keyStrobe,
    output logic [ChunkWidth-1:0]               dramWriteData,
    output logic                                dramWriteStrobe,
    output logic [ChunkWidth-1:0]               backendReadData,
    output logic                                backendReadStrobe
);

    chunkT chunkPipe [MixRounds];
    logic  headerPipe [MixRounds];
    logic  toBackendPipe [MixRounds];
    logic  strobePipe [MixRounds];

    chunkT result;
    logic  resultValid;

    // --------------------
    // Delay line, MixRounds deep to meet keyStrobe
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int s = 0; s < MixRounds; s++) begin
                strobePipe[s] <= 1'b0;
            end
        end else begin
            strobePipe[0] <= bus.strobe;
            for (int s = 1; s < MixRounds; s++) begin
                strobePipe[s] <= strobePipe[s-1];
            end
        end
    end

    always_ff @(posedge Clock) begin
        chunkPipe[0] <= bus.chunk;
        headerPipe[0] <= bus.isHeader;
        toBackendPipe[0] <= bus.toBackend;
        for (int s = 1; s < MixRounds; s++) begin
            chunkPipe[s] <= chunkPipe[s-1];
            headerPipe[s] <= headerPipe[s-1];
            toBackendPipe[s] <= toBackendPipe[s-1];
        end
    end

    // --------------------
    // Lane XOR
    always_comb begin
        for (int i = 0; i < LaneCount; i++) begin
            if (headerPipe[MixRounds-1]) begin
                result.lanes[i] = chunkPipe[MixRounds-1].lanes[i];
            end else begin
                result.lanes[i] = chunkPipe[MixRounds-1].lanes[i] ^ keyWord[i];
            end
        end
    end

    // Chunk and keystream arrive in the same cycle
    assign resultValid = strobePipe[MixRounds-1] & keyStrobe;

    // --------------------
    // Output routing
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            backendReadStrobe <= 1'b0;
            dramWriteStrobe <= 1'b0;
        end else begin
            backendReadStrobe <= resultValid & toBackendPipe[MixRounds-1];
            dramWriteStrobe <= resultValid & ~toBackendPipe[MixRounds-1];
        end
    end

    always_ff @(posedge Clock) begin
        if (resultValid && toBackendPipe[MixRounds-1]) begin
            backendReadData <= result;
        end
        if (resultValid && !toBackendPipe[MixRounds-1]) begin
            dramWriteData <= result;
        end
    end

endmodule

// File: logic/pathCipher.sv
// Top level of the bucket cipher
// Sequencer, keystream lanes and combiner wired together

`timescale 1ns/10ps

module pathCipher
    import cipherPkg::*;
(
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic [ChunkWidth-1:0] dramReadData,
    input  logic                  dramReadStrobe,
    input  logic [ChunkWidth-1:0] backendWriteData,
    input  logic                  backendWriteStrobe,
    output logic [ChunkWidth-1:0] dramWriteData,
    output logic                  dramWriteStrobe,
    output logic [ChunkWidth-1:0] backendReadData,
    output logic                  backendReadStrobe
);

    logic [LaneCount-1:0][LaneWidth-1:0] laneSeed;
    logic                                laneSeedStrobe;
    logic [LaneCount-1:0][LaneWidth-1:0] laneKeyWord;
    logic [LaneCount-1:0]                laneKeyStrobe;

    chunkBus bus ();

    pathSequencer sequencer (
        .Clock              (Clock),
        .rstN               (rstN),
        .dramReadData       (dramReadData),
        .dramReadStrobe     (dramReadStrobe),
        .backendWriteData   (backendWriteData),
        .backendWriteStrobe (backendWriteStrobe),
        .bus                (bus.sequencer),
        .seed               (laneSeed),
        .seedStrobe         (laneSeedStrobe)
    );

    // One mixer pipeline per 64-bit half
    for (genvar i = 0; i < LaneCount; i++) begin : gLane
        keystreamLane lane (
            .Clock      (Clock),
            .rstN       (rstN),
            .seed       (laneSeed[i]),
            .seedStrobe (laneSeedStrobe),
            .keyWord    (laneKeyWord[i]),
            .keyStrobe  (laneKeyStrobe[i])
        );
    end

    chunkCombiner combiner (
        .Clock             (Clock),
        .rstN              (rstN),
        .bus               (bus.combiner),
        .keyWord           (laneKeyWord),
        .keyStrobe         (&laneKeyStrobe),
        .dramWriteData     (dramWriteData),
        .dramWriteStrobe   (dramWriteStrobe),
        .backendReadData   (backendReadData),
        .backendReadStrobe (backendReadStrobe)
    );

endmodule

// File: logic/pathSequencer.sv
// Input selection by path direction, chunk and path position counting
// IV capture and per-lane seed generation

`timescale 1ns/10ps

module pathSequencer
    import cipherPkg::*;
(
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [ChunkWidth-1:0]               dramReadData,
    input  logic                                dramReadStrobe,
    input  logic [ChunkWidth-1:0]               backendWriteData,
    input  logic                                backendWriteStrobe,
    chunkBus.sequencer                          bus,
    output logic [LaneCount-1:0][LaneWidth-1:0] seed,
    output logic                                seedStrobe
);

    // High on path read (DRAM to backend), low on path write
    logic                      toBackend;
    logic [PathIdxWidth-1:0]   pathIdx;
    logic [BucketIdxWidth-1:0] chunkIdx;
    logic [LaneWidth-1:0]      ivReg;

    chunkT                     inChunk;
    logic                      inStrobe;
    logic                      inHeader;
    logic                      lastOfPath;
    logic [LaneWidth-1:0]      seedBase;

    // --------------------
    // Input select
    // Only the side that is active in this direction is looked at
    assign inChunk = toBackend ? dramReadData : backendWriteData;
    assign inStrobe = toBackend ? dramReadStrobe : backendWriteStrobe;

    // Chunk index within the bucket is the low part of the path index
    assign chunkIdx = pathIdx[BucketIdxWidth-1:0];
    assign inHeader = (chunkIdx == '0);
    assign lastOfPath = (pathIdx == PathIdxWidth'(PathChunks - 1));

    // Header chunks seed from the IV arriving with them
    assign seedBase = inHeader ? inChunk.header.iv : ivReg;

    // --------------------
    // Position counting and direction
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pathIdx <= '0;
            toBackend <= 1'b1;
            bus.strobe <= 1'b0;
            seedStrobe <= 1'b0;
        end else begin
            bus.strobe <= inStrobe;
            seedStrobe <= inStrobe;
            if (inStrobe) begin
                pathIdx <= pathIdx + 1'b1;
                // Flip sides once the path is complete
                if (lastOfPath) begin
                    toBackend <= ~toBackend;
                end
            end
        end
    end

    // --------------------
    // Payload registers
    always_ff @(posedge Clock) begin
        if (inStrobe) begin
            if (inHeader) begin
                ivReg <= inChunk.header.iv;
            end
            bus.chunk <= inChunk;
            bus.isHeader <= inHeader;
            bus.toBackend <= toBackend;
            // Lane i counter is chunk index times LaneCount plus i
            for (int i = 0; i < LaneCount; i++) begin
                seed[i] <= seedBase
                    + LaneWidth'(chunkIdx) * LaneWidth'(LaneCount)
                    + LaneWidth'(i);
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the bucket cipher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module pathCipherTb -o pathCipherSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/pathCipherSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verilog.f
common/cipherPkg.sv
common/chunkBus.sv
keystream/keystreamLane.sv
logic/pathSequencer.sv
logic/chunkCombiner.sv
logic/pathCipher.sv
bench/pathCipherTb.sv
